// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dsi_packet_assembler
RTL_TOP   ?= dsi_packet_assembler
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
INC_DIR   ?= design
RTL_SRCS  ?= design/dsi_pkg.sv design/packet_decoder.sv design/crc16_calculator.sv \
             design/payload_sequencer.sv design/lane_writer.sv design/dsi_packet_assembler.sv
VFLAGS    ?= --timing --assert --timescale 1ns/100ps -Wno-fatal
PASS_MSG  ?= STATUS: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) +incdir+$(INC_DIR) --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== design/crc16_calculator.sv ====
`include "dsi_settings.svh"

module crc16_calculator
(
    input  logic                   clk_sys,
    input  logic                   reset,
    input  logic                   clear,
    input  logic                   data_write,
    input  logic [2:0]             bytes_number,
    input  logic [`DSI_WORD_W-1:0] data_input,
    output logic [15:0]            crc_async
);

    logic [15:0] crc_q;
    logic [15:0] crc_next;

    // one byte through the reflected polynomial, LSB first
    function automatic logic [15:0] crc_byte(input logic [15:0] crc_in, input logic [7:0] data);
        logic [15:0] c;
        c = crc_in ^ {8'h00, data};
        for (int b = 0; b < 8; b++)
        begin
            c = c[0] ? ((c >> 1) ^ `DSI_CRC_POLY) : (c >> 1);
        end
        return c;
    endfunction

    always_comb
    begin
        crc_next = crc_q;
        for (int i = 0; i < `DSI_BYTES_PER_WORD; i++)
        begin
            if (i < bytes_number)
                crc_next = crc_byte(crc_next, data_input[8*i +: 8]);
        end
    end

    assign crc_async = data_write ? crc_next : crc_q;    // already holds the word being written

    always_ff @(posedge clk_sys)
    begin
        if (reset || clear)
            crc_q <= `DSI_CRC_SEED;
        else if (data_write)
            crc_q <= crc_next;
    end

    assert property (@(posedge clk_sys) disable iff (reset) data_write |-> bytes_number <= 3'd4)
        else $error("crc16_calculator: bytes_number %0d out of range", bytes_number);

endmodule

// ==== design/dsi_packet_assembler.sv ====
`include "dsi_settings.svh"

module dsi_packet_assembler
(
    input  logic                           clk_sys,
    input  logic                           reset,
    input  logic [`DSI_WORD_W-1:0]         usr_fifo_data,
    input  logic                           usr_fifo_empty,
    output logic                           usr_fifo_read,
    output logic [`DSI_WORD_W-1:0]         iface_write_data,
    output logic [`DSI_BYTES_PER_WORD-1:0] iface_write_strb,
    output logic                           iface_write_rqst,
    output logic                           iface_last_word,
    input  logic                           iface_data_rqst,
    output logic                           packet_error
);
    import dsi_pkg::*;

    packet_info_t info;
    lane_beat_t   beat;
    logic         beat_ready;

    packet_decoder decoder_inst
    (
        .head       (usr_fifo_data),
        .head_valid (!usr_fifo_empty),     // show-ahead FIFO, head is valid whenever not empty
        .info       (info)
    );

    payload_sequencer sequencer_inst
    (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .usr_fifo_data  (usr_fifo_data),
        .usr_fifo_empty (usr_fifo_empty),
        .usr_fifo_read  (usr_fifo_read),
        .info           (info),
        .beat           (beat),
        .beat_ready     (beat_ready),
        .packet_error   (packet_error)
    );

    lane_writer writer_inst
    (
        .clk_sys          (clk_sys),
        .reset            (reset),
        .beat             (beat),
        .beat_ready       (beat_ready),
        .iface_write_data (iface_write_data),
        .iface_write_strb (iface_write_strb),
        .iface_write_rqst (iface_write_rqst),
        .iface_last_word  (iface_last_word),
        .iface_data_rqst  (iface_data_rqst)
    );

endmodule

// ==== design/dsi_pkg.sv ====
`include "dsi_settings.svh"

package dsi_pkg;

    // header view of a FIFO word, data_id sits in byte 0
    typedef struct packed {
        logic [7:0]           ecc;          // slot left empty by the user, filled on the way out
        logic [`DSI_WC_W-1:0] word_count;
        logic [7:0]           data_id;
    } fifo_hdr_t;

    typedef union packed {
        fifo_hdr_t                           hdr;
        logic [`DSI_BYTES_PER_WORD-1:0][7:0] bytes;    // payload view, byte 0 goes out first
    } fifo_word_u;

    typedef struct packed {
        logic                 is_long;
        logic                 is_error;     // reserved data type, header gets dropped
        logic [`DSI_WC_W-1:0] word_count;
        logic [7:0]           ecc;
        logic [7:0]           data_id;
        logic                 hdr_valid;
    } packet_info_t;

    typedef struct packed {
        logic [`DSI_WORD_W-1:0] data;
        logic [2:0]             n_bytes;        // valid bytes from byte 0 upward
        logic                   crc_follows;    // last payload beat of a long packet
        logic [15:0]            crc;
        logic                   is_header;
        logic                   short_last;     // header of a short packet ends it
        logic                   valid;
    } lane_beat_t;

endpackage

// ==== design/dsi_settings.svh ====
`ifndef DSI_SETTINGS_SVH
`define DSI_SETTINGS_SVH

// lane and FIFO word geometry
`define DSI_WORD_W          32
`define DSI_BYTES_PER_WORD  4

// long packet word count as carried in the header
`define DSI_WC_W            16

`define DSI_CRC_SEED        16'hFFFF    // CRC register start value
`define DSI_CRC_POLY        16'h8408    // CCITT polynomial, bit reversed for LSB-first

`endif

// ==== design/lane_writer.sv ====
`include "dsi_settings.svh"

module lane_writer
(
    input  logic                          clk_sys,
    input  logic                          reset,
    input  dsi_pkg::lane_beat_t           beat,
    output logic                          beat_ready,
    output logic [`DSI_WORD_W-1:0]        iface_write_data,
    output logic [`DSI_BYTES_PER_WORD-1:0] iface_write_strb,
    output logic                          iface_write_rqst,
    output logic                          iface_last_word,
    input  logic                          iface_data_rqst
);

    logic                   out_free;
    logic                   crc_merge;      // CRC fits into the final payload word
    logic                   crc_split;      // CRC spills into one more word
    logic                   carry_pend;
    logic [15:0]            carry_crc;
    logic [2:0]             carry_bytes;
    logic [`DSI_WORD_W-1:0] merged_data;
    logic [2:0]             merged_bytes;

    function automatic logic [3:0] strobe_of(input logic [2:0] n);
        case (n)
            3'd0:    return 4'b0000;
            3'd1:    return 4'b0001;
            3'd2:    return 4'b0011;
            3'd3:    return 4'b0111;
            default: return 4'b1111;
        endcase
    endfunction

    assign out_free   = !iface_write_rqst || iface_data_rqst;   // empty or leaving this cycle
    assign beat_ready = out_free && !carry_pend;

    assign crc_merge = beat.crc_follows && (beat.n_bytes <= 3'd2);
    assign crc_split = beat.crc_follows && (beat.n_bytes > 3'd2);

    // low CRC byte lands right after the last payload byte
    always_comb
    begin
        merged_data  = beat.data;
        merged_bytes = beat.n_bytes;
        if (beat.crc_follows)
        begin
            merged_data  = beat.data | ({{(`DSI_WORD_W-16){1'b0}}, beat.crc} << (8 * beat.n_bytes));
            merged_bytes = crc_merge ? (beat.n_bytes + 3'd2) : 3'd4;
        end
    end

    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            iface_write_rqst <= 1'b0;
            iface_write_strb <= '0;
            iface_last_word  <= 1'b0;
            carry_pend       <= 1'b0;
        end
        else if (out_free)
        begin
            if (carry_pend)
            begin
                iface_write_rqst <= 1'b1;
                iface_write_strb <= strobe_of(carry_bytes);
                iface_last_word  <= 1'b1;
                carry_pend       <= 1'b0;
            end
            else if (beat.valid)
            begin
                iface_write_rqst <= 1'b1;
                iface_write_strb <= beat.is_header ? 4'b1111 : strobe_of(merged_bytes);
                iface_last_word  <= beat.short_last || crc_merge;
                carry_pend       <= crc_split;
            end
            else
                iface_write_rqst <= 1'b0;
        end
    end

    always_ff @(posedge clk_sys)
    begin
        if (out_free)
        begin
            if (carry_pend)
                iface_write_data <= {{(`DSI_WORD_W-16){1'b0}}, carry_crc};
            else if (beat.valid)
                iface_write_data <= merged_data;
        end
        if (beat_ready && beat.valid && crc_split)
        begin
            // a full word leaves both bytes over while three bytes leave only the high one
            carry_crc   <= (beat.n_bytes == 3'd4) ? beat.crc : {8'h00, beat.crc[15:8]};
            carry_bytes <= (beat.n_bytes == 3'd4) ? 3'd2 : 3'd1;
        end
    end

    assert property (@(posedge clk_sys) disable iff (reset) beat.valid |-> beat.n_bytes <= 3'd4)
        else $error("lane_writer: beat carries %0d bytes", beat.n_bytes);

endmodule

// ==== design/packet_decoder.sv ====
module packet_decoder
(
    input  dsi_pkg::fifo_word_u   head,
    input  logic                  head_valid,
    output dsi_pkg::packet_info_t info
);
    import dsi_pkg::*;

    // data bits covered by each of the six DSI ECC parity bits with P5 first
    localparam logic [5:0][23:0] ECC_MASK = {
        24'hEFFC00,
        24'hDF03F0,
        24'hB8E38E,
        24'h749A6D,
        24'hF2555B,
        24'hF12CB7
    };

    fifo_hdr_t   hdr;
    logic [23:0] ecc_data;
    logic [5:0]  parity;
    logic [3:0]  data_type;

    assign hdr       = head.hdr;
    assign ecc_data  = {hdr.word_count, hdr.data_id};   // D23..D0 as the ECC sees them
    assign data_type = hdr.data_id[3:0];

    always_comb
    begin
        for (int i = 0; i < 6; i++)
        begin
            parity[i] = ^(ecc_data & ECC_MASK[i]);
        end
    end

    always_comb
    begin
        info.hdr_valid  = head_valid;
        info.data_id    = hdr.data_id;
        info.word_count = hdr.word_count;
        info.ecc        = {2'b00, parity};                       // top two ECC bits stay zero
        info.is_error   = (data_type == 4'h0) || (data_type == 4'hF);
        case (data_type)
            4'h9, 4'hC, 4'hD, 4'hE: info.is_long = 1'b1;
            default:                info.is_long = 1'b0;
        endcase
    end

endmodule

// ==== design/payload_sequencer.sv ====
`include "dsi_settings.svh"

module payload_sequencer
(
    input  logic                   clk_sys,
    input  logic                   reset,
    input  logic [`DSI_WORD_W-1:0] usr_fifo_data,
    input  logic                   usr_fifo_empty,
    output logic                   usr_fifo_read,
    input  dsi_pkg::packet_info_t  info,
    output dsi_pkg::lane_beat_t    beat,
    input  logic                   beat_ready,
    output logic                   packet_error
);
    import dsi_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_PAYLOAD, S_DRAIN} seq_state_t;

    seq_state_t  state;
    logic        started;       // holds off FIFO pops for one cycle after reset
    logic [16:0] bytes_left;
    logic [2:0]  n_bytes;
    logic        last_word;
    logic        hdr_pop;
    logic        pay_pop;
    logic        issue;
    logic        beat_valid;
    logic [15:0] crc_async;
    fifo_word_u  fifo_word;
    fifo_word_u  masked_word;
    lane_beat_t  beat_next;
    lane_beat_t  beat_q;

    assign fifo_word = usr_fifo_data;
    assign n_bytes   = (bytes_left >= 17'd4) ? 3'd4 : bytes_left[2:0];
    assign last_word = (bytes_left <= 17'd4);

    // bytes past the end of the payload go out as zero
    always_comb
    begin
        for (int i = 0; i < `DSI_BYTES_PER_WORD; i++)
        begin
            masked_word.bytes[i] = (i < n_bytes) ? fifo_word.bytes[i] : 8'h00;
        end
    end

    assign hdr_pop       = started && beat_ready && (state == S_IDLE) && info.hdr_valid;
    assign pay_pop       = beat_ready && (state == S_PAYLOAD) && !usr_fifo_empty;
    assign usr_fifo_read = hdr_pop || pay_pop;

    crc16_calculator crc_inst
    (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .clear        (hdr_pop),
        .data_write   (pay_pop),
        .bytes_number (n_bytes),
        .data_input   (masked_word),
        .crc_async    (crc_async)
    );

    always_comb
    begin
        beat_next       = '0;
        beat_next.valid = 1'b1;
        issue           = 1'b0;
        case (state)
            S_IDLE:
            begin
                beat_next.data       = {info.ecc, info.word_count, info.data_id};
                beat_next.n_bytes    = 3'd4;
                beat_next.is_header  = 1'b1;
                beat_next.short_last = !info.is_long;
                issue                = hdr_pop && !info.is_error;
            end
            S_PAYLOAD:
            begin
                beat_next.data        = masked_word;
                beat_next.n_bytes     = n_bytes;
                beat_next.crc_follows = last_word;
                beat_next.crc         = crc_async;
                issue                 = pay_pop;
            end
            S_DRAIN:
            begin
                beat_next.crc_follows = 1'b1;   // empty payload, the seed CRC goes out alone
                beat_next.crc         = crc_async;
                issue                 = 1'b1;
            end
            default:
                issue = 1'b0;
        endcase
    end

    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            state        <= S_IDLE;
            started      <= 1'b0;
            bytes_left   <= '0;
            packet_error <= 1'b0;
            beat_valid   <= 1'b0;
        end
        else
        begin
            started      <= 1'b1;
            packet_error <= hdr_pop && info.is_error;
            if (beat_ready)
                beat_valid <= issue;
            if (hdr_pop && info.is_long)
            begin
                bytes_left <= 17'(info.word_count);
                state      <= (info.word_count == '0) ? S_DRAIN : S_PAYLOAD;
            end
            else if (pay_pop)
            begin
                bytes_left <= bytes_left - 17'(n_bytes);
                if (last_word)
                    state <= S_IDLE;
            end
            else if ((state == S_DRAIN) && beat_ready)
                state <= S_IDLE;
        end
    end

    always_ff @(posedge clk_sys)
    begin
        if (beat_ready && issue)
            beat_q <= beat_next;
    end

    always_comb
    begin
        beat       = beat_q;
        beat.valid = beat_valid;
    end

    assert property (@(posedge clk_sys) disable iff (reset) !(usr_fifo_read && usr_fifo_empty))
        else $error("payload_sequencer: pop from an empty user FIFO");

endmodule

// ==== sim.f ====
+incdir+design
design/dsi_pkg.sv
design/packet_decoder.sv
design/crc16_calculator.sv
design/payload_sequencer.sv
design/lane_writer.sv
design/dsi_packet_assembler.sv
sim/tb_dsi_packet_assembler.sv

// ==== sim/tb_dsi_packet_assembler.sv ====
`include "dsi_settings.svh"

module tb_dsi_packet_assembler;
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } lane_word_t;

    logic        clk_sys;
    logic        reset;
    logic [31:0] usr_fifo_data;
    logic        usr_fifo_empty;
    logic        usr_fifo_read;
    logic [31:0] iface_write_data;
    logic [3:0]  iface_write_strb;
    logic        iface_write_rqst;
    logic        iface_last_word;
    logic        iface_data_rqst;
    logic        packet_error;

    logic [31:0] fifo_q[$];        // show-ahead user FIFO contents
    lane_word_t  exp_q[$];         // scoreboard of lane words in order
    string       name_q[$];
    integer      seed;
    int          error_count = 0;
    int          words_checked = 0;
    int          pulse_count = 0;
    int          pulses_expected = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    logic [15:0] wc_list[7] = '{16'd0, 16'd1, 16'd2, 16'd3, 16'd4, 16'd5, 16'd7};

    dsi_packet_assembler UUT
    (
        .clk_sys          (clk_sys),
        .reset            (reset),
        .usr_fifo_data    (usr_fifo_data),
        .usr_fifo_empty   (usr_fifo_empty),
        .usr_fifo_read    (usr_fifo_read),
        .iface_write_data (iface_write_data),
        .iface_write_strb (iface_write_strb),
        .iface_write_rqst (iface_write_rqst),
        .iface_last_word  (iface_last_word),
        .iface_data_rqst  (iface_data_rqst),
        .packet_error     (packet_error)
    );

    // DSI Hamming parity over header bits D23..D0
    function automatic logic [7:0] ecc_of(input logic [23:0] d);
        logic [5:0] p;
        p[0] = d[0]^d[1]^d[2]^d[4]^d[5]^d[7]^d[10]^d[11]^d[13]^d[16]^d[20]^d[21]^d[22]^d[23];
        p[1] = d[0]^d[1]^d[3]^d[4]^d[6]^d[8]^d[10]^d[12]^d[14]^d[17]^d[20]^d[21]^d[22]^d[23];
        p[2] = d[0]^d[2]^d[3]^d[5]^d[6]^d[9]^d[11]^d[12]^d[15]^d[18]^d[20]^d[21]^d[22];
        p[3] = d[1]^d[2]^d[3]^d[7]^d[8]^d[9]^d[13]^d[14]^d[15]^d[19]^d[20]^d[21]^d[23];
        p[4] = d[4]^d[5]^d[6]^d[7]^d[8]^d[9]^d[16]^d[17]^d[18]^d[19]^d[20]^d[22]^d[23];
        p[5] = d[10]^d[11]^d[12]^d[13]^d[14]^d[15]^d[16]^d[17]^d[18]^d[19]^d[21]^d[22]^d[23];
        return {2'b00, p};
    endfunction

    // serial CRC one bit at a time with the LSB of each byte first
    function automatic logic [15:0] crc_step(input logic [15:0] crc, input logic [7:0] data);
        logic fb;
        for (int b = 0; b < 8; b++)
        begin
            fb  = crc[0] ^ data[b];
            crc = crc >> 1;
            if (fb)
                crc = crc ^ `DSI_CRC_POLY;
        end
        return crc;
    endfunction

    function automatic logic is_long_type(input logic [3:0] dt);
        return (dt == 4'h9) || (dt == 4'hC) || (dt == 4'hD) || (dt == 4'hE);
    endfunction

    // loads one packet into the FIFO model and its lane words into the scoreboard
    task automatic add_packet(input string name, input logic [7:0] data_id, input logic [15:0] wc);
        logic [7:0]  stream[$];
        logic [31:0] word;
        logic [15:0] crc;
        lane_word_t  exp;
        int          n_words;
        word = {8'($random(seed)), wc, data_id};    // top byte is the unused ECC slot
        fifo_q.push_back(word);
        if (data_id[3:0] == 4'h0 || data_id[3:0] == 4'hF)
        begin
            pulses_expected++;
            return;
        end
        exp.data = {ecc_of(word[23:0]), word[23:0]};
        exp.strb = 4'hF;
        exp.last = !is_long_type(data_id[3:0]);
        exp_q.push_back(exp);
        name_q.push_back(name);
        if (exp.last)
            return;
        crc     = `DSI_CRC_SEED;
        n_words = (wc + 3) / 4;
        for (int i = 0; i < n_words; i++)
        begin
            word = $random(seed);                   // bytes past word_count are junk
            fifo_q.push_back(word);
            for (int b = 0; b < 4; b++)
            begin
                if (4 * i + b < wc)
                begin
                    stream.push_back(word[8*b +: 8]);
                    crc = crc_step(crc, word[8*b +: 8]);
                end
            end
        end
        stream.push_back(crc[7:0]);
        stream.push_back(crc[15:8]);
        for (int i = 0; i < stream.size(); i += 4)
        begin
            exp = '0;
            for (int b = 0; b < 4; b++)
            begin
                if (i + b < stream.size())
                begin
                    exp.data[8*b +: 8] = stream[i + b];
                    exp.strb[b]        = 1'b1;
                end
            end
            exp.last = (i + 4 >= stream.size());
            exp_q.push_back(exp);
            name_q.push_back(name);
        end
    endtask

    task automatic finish_run();
        $display("summary: %0d errors, %0d words checked, %0d of %0d packet errors seen",
                 error_count, words_checked, pulse_count, pulses_expected);
        if (error_count == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    endtask

    initial
    begin
        clk_sys = 1'b0;
        forever #4 clk_sys = ~clk_sys;
    end

    // show-ahead FIFO where a read pops the head in the same cycle
    always @(posedge clk_sys)
    begin
        if (!reset && usr_fifo_read && fifo_q.size() > 0)
            void'(fifo_q.pop_front());
        usr_fifo_empty <= (fifo_q.size() == 0);
        usr_fifo_data  <= (fifo_q.size() > 0) ? fifo_q[0] : 32'h0;
    end

    always @(posedge clk_sys)
    begin
        iface_data_rqst <= (($random(seed) & 3) != 0);   // lane stalls about one cycle in four
    end

    always @(posedge clk_sys)
    begin
        lane_word_t exp;
        string      name;
        if (!reset && packet_error)
            pulse_count++;
        if (!reset && iface_write_rqst && iface_data_rqst)
        begin
            if (exp_q.size() == 0)
            begin
                error_count++;
                $display("lane sent word %h while no packet was outstanding", iface_write_data);
            end
            else
            begin
                exp  = exp_q.pop_front();
                name = name_q.pop_front();
                words_checked++;
                assert (iface_write_data == exp.data)
                else
                begin
                    error_count++;
                    $display("ERR %s data expected %h actual %h", name, exp.data, iface_write_data);
                end
                assert (iface_write_strb == exp.strb)
                else
                begin
                    error_count++;
                    $display("ERR %s strobe expected %b actual %b", name, exp.strb, iface_write_strb);
                end
                assert (iface_last_word == exp.last)
                else
                begin
                    error_count++;
                    $display("ERR %s last expected %b actual %b", name, exp.last, iface_last_word);
                end
            end
        end
    end

    always @(posedge clk_sys)
    begin
        cycle_count++;
        if (cycle_count >= cycle_limit)
        begin
            error_count++;
            $display("timeout after %0d cycles with %0d lane words still missing",
                     cycle_count, exp_q.size());
            finish_run();
        end
    end

    assert property (@(posedge clk_sys) $fell(reset) |-> !iface_write_rqst && !iface_last_word
                     && !usr_fifo_read && !packet_error && (iface_write_strb == 4'b0000))
    else
    begin
        error_count++;
        $display("outputs were not idle in the first cycle after reset");
    end

    assert property (@(posedge clk_sys) disable iff (reset)
                     iface_write_rqst && !iface_data_rqst |=> iface_write_rqst
                     && $stable(iface_write_data) && $stable(iface_write_strb)
                     && $stable(iface_last_word))
    else
    begin
        error_count++;
        $display("lane outputs changed while the lane was stalled");
    end

    assert property (@(posedge clk_sys) disable iff (reset) packet_error |=> !packet_error)
    else
    begin
        error_count++;
        $display("packet_error stayed high for more than one cycle");
    end

    assert property (@(posedge clk_sys) disable iff (reset) usr_fifo_read |-> !usr_fifo_empty)
    else
    begin
        error_count++;
        $display("user FIFO was read while empty");
    end

    initial
    begin
        logic [7:0]  id;
        logic [15:0] wc;
        reset           = 1'b1;
        usr_fifo_data   = 32'h0;
        usr_fifo_empty  = 1'b1;
        iface_data_rqst = 1'b0;
        seed            = 32'h9187_62e1;
        add_packet("short_a", 8'h05, 16'h1234);
        add_packet("short_b", 8'h23, 16'hBEEF);
        foreach (wc_list[i])
            add_packet($sformatf("long_wc%0d", wc_list[i]), 8'h29, wc_list[i]);
        add_packet("reserved_00", 8'h00, 16'h0042);
        add_packet("after_reserved_00", 8'h15, 16'h5A5A);
        add_packet("reserved_0f", 8'h0F, 16'h0003);
        add_packet("after_reserved_0f", 8'h1E, 16'd6);
        for (int k = 0; k < 30; k++)
        begin
            id = 8'($random(seed));
            while (id[3:0] == 4'h0 || id[3:0] == 4'hF)
                id = 8'($random(seed));
            if (is_long_type(id[3:0]))
                add_packet("random_long", id, 16'({$random(seed)} % 24));
            else
                add_packet("random_short", id, 16'($random(seed)));
        end
        cycle_limit = 8 * exp_q.size() + 200;
        repeat (5) @(posedge clk_sys);
        reset <= 1'b0;
        while (exp_q.size() != 0)
            @(posedge clk_sys);
        repeat (20) @(posedge clk_sys);     // any extra lane word shows up here
        assert (pulse_count == pulses_expected)
        else
        begin
            error_count++;
            $display("ERR reserved packet_error pulses expected %0d actual %0d",
                     pulses_expected, pulse_count);
        end
        assert (fifo_q.size() == 0)
        else
        begin
            error_count++;
            $display("user FIFO still holds %0d words at the end", fifo_q.size());
        end
        finish_run();
    end

endmodule
